/* rtl/dz_pkg.sv */
package dz_pkg;

    // matrix geometry
    localparam int LINE_W  = 8;
    localparam int DIGIT_W = 3;
    localparam int SCAN_W  = 3;

    // one row or column vector of the matrix
    typedef logic [LINE_W-1:0] line_t;

    // displayed number where 0 means blank
    typedef logic [DIGIT_W-1:0] digit_t;

    // row index 0..7
    typedef logic [SCAN_W-1:0] scan_t;

    // select shows red and locked shows green
    typedef enum logic {
        MODE_SELECT = 1'b0,
        MODE_LOCKED = 1'b1
    } mode_t;

    localparam digit_t MAX_DIGIT = 3'd4;   // highest glyph in the table

endpackage

/* rtl/row_tick.sv */
`timescale 1ns/10ps

module row_tick #(
    parameter int TICK_DIV = 50000
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int CW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [CW-1:0] CNT_LAST = CW'(TICK_DIV - 1);

    logic [CW-1:0] cnt;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt  <= '0;
            tick <= 1'b0;
        end
        else if (cnt == CNT_LAST)
        begin
            cnt  <= '0;
            tick <= 1'b1;   // one pulse per wrap
        end
        else
        begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

/* rtl/key_debounce.sv */
`timescale 1ns/10ps

module key_debounce #(
    parameter int DEBOUNCE_CYCLES = 500000
) (
    input  logic clk,
    input  logic rst,
    input  logic btn_inc,
    input  logic btn_dec,
    input  logic btn_cfm,
    output logic inc_stb,
    output logic dec_stb,
    output logic cfm_stb
);

    localparam int NKEY = 3;
    localparam int CW = $clog2(DEBOUNCE_CYCLES + 1);
    localparam logic [CW-1:0] CNT_LAST = CW'(DEBOUNCE_CYCLES - 1);

    logic [NKEY-1:0] raw;
    logic [NKEY-1:0] sync1;
    logic [NKEY-1:0] sync2;
    logic [NKEY-1:0] level;     // accepted level per button
    logic [NKEY-1:0] stb;
    logic [CW-1:0]   cnt [NKEY];

    assign raw = {btn_cfm, btn_dec, btn_inc};

    // two-flop synchronizer
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sync1 <= '0;
            sync2 <= '0;
        end
        else
        begin
            sync1 <= raw;
            sync2 <= sync1;
        end
    end

    // count samples that disagree with the accepted level
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            level <= '0;
            stb   <= '0;
            for (int i = 0; i < NKEY; i++)
                cnt[i] <= '0;
        end
        else
        begin
            for (int i = 0; i < NKEY; i++)
            begin
                stb[i] <= 1'b0;
                if (sync2[i] == level[i])
                    cnt[i] <= '0;
                else if (cnt[i] == CNT_LAST)
                begin
                    cnt[i]   <= '0;
                    level[i] <= sync2[i];
                    stb[i]   <= ~level[i];  // strobe on press only
                end
                else
                    cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end

    assign inc_stb = stb[0];
    assign dec_stb = stb[1];
    assign cfm_stb = stb[2];

endmodule

/* rtl/dz_ctrl.sv */
`timescale 1ns/10ps

module dz_ctrl (
    input  logic            clk,
    input  logic            rst,
    input  logic            inc_stb,
    input  logic            dec_stb,
    input  logic            cfm_stb,
    output dz_pkg::digit_t  digit,
    output dz_pkg::mode_t   mode
);

    dz_pkg::digit_t digit_n;
    dz_pkg::mode_t  mode_n;
    dz_pkg::digit_t digit_up;
    dz_pkg::digit_t digit_dn;

    // wrap within 0..MAX_DIGIT
    assign digit_up = (digit == dz_pkg::MAX_DIGIT) ? '0 : digit + 1'b1;
    assign digit_dn = (digit == '0) ? dz_pkg::MAX_DIGIT : digit - 1'b1;

    always_comb
    begin
        digit_n = digit;
        mode_n  = mode;
        case (mode)
            dz_pkg::MODE_SELECT:
            begin
                if (cfm_stb)
                    mode_n = dz_pkg::MODE_LOCKED;
                else if (inc_stb)
                    digit_n = digit_up;
                else if (dec_stb)
                    digit_n = digit_dn;
            end
            dz_pkg::MODE_LOCKED:
            begin
                // digit frozen so only confirm matters
                if (cfm_stb)
                    mode_n = dz_pkg::MODE_SELECT;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            digit <= '0;
            mode  <= dz_pkg::MODE_SELECT;
        end
        else
        begin
            digit <= digit_n;
            mode  <= mode_n;
        end
    end

endmodule

/* rtl/dz_scan.sv */
`timescale 1ns/10ps

module dz_scan (
    input  logic            clk,
    input  logic            rst,
    input  logic            tick,
    input  dz_pkg::digit_t  digit,
    input  dz_pkg::mode_t   mode,
    output dz_pkg::line_t   row,
    output dz_pkg::line_t   colr,
    output dz_pkg::line_t   colg
);

    dz_pkg::scan_t idx;
    logic          upd;     // index moved last cycle
    dz_pkg::line_t pat;

    // column pattern of one glyph row
    function automatic dz_pkg::line_t glyph(input dz_pkg::digit_t d, input dz_pkg::scan_t r);
        dz_pkg::line_t p;
        p = 8'b0000_0000;
        case (d)
            3'd1:
            begin
                case (r)
                    3'd1, 3'd4: p = 8'b0011_1100;
                    3'd2, 3'd3: p = 8'b0010_0000;
                    default:    p = 8'b0000_0000;
                endcase
            end
            3'd2:
            begin
                case (r)
                    3'd1, 3'd4: p = 8'b0011_1100;
                    3'd2, 3'd3: p = 8'b0000_0100;
                    default:    p = 8'b0000_0000;
                endcase
            end
            3'd3:
            begin
                case (r)
                    3'd1:             p = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4: p = 8'b0010_0100;
                    default:          p = 8'b0000_0000;
                endcase
            end
            3'd4:
            begin
                case (r)
                    3'd1, 3'd4: p = 8'b0010_0100;
                    3'd2, 3'd3: p = 8'b0011_1100;
                    default:    p = 8'b0000_0000;
                endcase
            end
            default: p = 8'b0000_0000;     // 0 is blank
        endcase
        return p;
    endfunction

    assign pat = glyph(digit, idx);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            idx <= '0;
            upd <= 1'b0;
        end
        else
        begin
            upd <= tick;
            if (tick)
                idx <= idx + 1'b1;  // wraps 7 -> 0
        end
    end

    // outputs load together and hold for the whole row
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= '1;     // nothing lit
            colr <= '0;
            colg <= '0;
        end
        else if (upd)
        begin
            row  <= ~(dz_pkg::line_t'(1) << idx);
            colr <= (mode == dz_pkg::MODE_SELECT) ? pat : '0;
            colg <= (mode == dz_pkg::MODE_LOCKED) ? pat : '0;
        end
    end

endmodule

/* rtl/dz_top.sv */
`timescale 1ns/10ps

module dz_top #(
    parameter int TICK_DIV        = 50000,    // 1 kHz rows at 50 MHz
    parameter int DEBOUNCE_CYCLES = 500000
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            btn_inc,
    input  logic            btn_dec,
    input  logic            btn_cfm,
    output dz_pkg::line_t   row,
    output dz_pkg::line_t   colr,
    output dz_pkg::line_t   colg
);

    logic           inc_stb;
    logic           dec_stb;
    logic           cfm_stb;
    logic           tick;
    dz_pkg::digit_t digit;
    dz_pkg::mode_t  mode;

    key_debounce #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_keys (
        .clk     (clk),
        .rst     (rst),
        .btn_inc (btn_inc),
        .btn_dec (btn_dec),
        .btn_cfm (btn_cfm),
        .inc_stb (inc_stb),
        .dec_stb (dec_stb),
        .cfm_stb (cfm_stb)
    );

    dz_ctrl u_ctrl (
        .clk     (clk),
        .rst     (rst),
        .inc_stb (inc_stb),
        .dec_stb (dec_stb),
        .cfm_stb (cfm_stb),
        .digit   (digit),
        .mode    (mode)
    );

    row_tick #(
        .TICK_DIV (TICK_DIV)
    ) u_tick (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    dz_scan u_scan (
        .clk   (clk),
        .rst   (rst),
        .tick  (tick),
        .digit (digit),
        .mode  (mode),
        .row   (row),
        .colr  (colr),
        .colg  (colg)
    );

endmodule

/* bench/dz_checker.sv */
`timescale 1ns/10ps

module dz_checker #(
    parameter int NAME_W = 128
) (
    input  logic              clk,
    input  dz_pkg::line_t     row,
    input  dz_pkg::line_t     colr,
    input  dz_pkg::line_t     colg,
    input  logic              chk_req,
    input  dz_pkg::digit_t    exp_digit,
    input  dz_pkg::mode_t     exp_mode,
    input  logic [NAME_W-1:0] test_name,
    output logic              chk_done,
    output int                pass_cnt,
    output int                fail_cnt
);

    localparam dz_pkg::line_t BARS  = 8'b0011_1100;   // bits 5 down to 2
    localparam dz_pkg::line_t LEFT  = 8'b0010_0000;   // bit 5
    localparam dz_pkg::line_t RIGHT = 8'b0000_0100;   // bit 2
    localparam dz_pkg::line_t SIDES = 8'b0010_0100;   // bits 5 and 2

    // columns of glyph d on matrix row r
    function automatic dz_pkg::line_t expected_cols(input dz_pkg::digit_t d, input int r);
        logic outer;
        outer = (r == 1) || (r == 4);
        if (d == 0 || d > dz_pkg::MAX_DIGIT || r < 1 || r > 4)
            return '0;
        case (d)
            3'd1:    return outer ? BARS : LEFT;
            3'd2:    return outer ? BARS : RIGHT;
            3'd3:    return (r == 1) ? BARS : SIDES;
            default: return outer ? SIDES : BARS;
        endcase
    endfunction

    // index of the single low bit or -1 when not one-hot
    function automatic int lit_row(input dz_pkg::line_t r);
        int idx;
        int zeros;
        idx = -1;
        zeros = 0;
        for (int k = 0; k < 8; k++)
        begin
            if (!r[k])
            begin
                zeros++;
                idx = k;
            end
        end
        return (zeros == 1) ? idx : -1;
    endfunction

    task automatic check_frame();
        logic [7:0]        seen;
        logic [NAME_W-1:0] name;
        dz_pkg::digit_t    d;
        dz_pkg::mode_t     m;
        dz_pkg::line_t     pat;
        dz_pkg::line_t     exp_r;
        dz_pkg::line_t     exp_g;
        dz_pkg::line_t     bad_row_val;
        dz_pkg::line_t     got_r;
        dz_pkg::line_t     got_g;
        dz_pkg::line_t     want_r;
        dz_pkg::line_t     want_g;
        int                r;
        int                bad_row;
        int                bad_val;
        int                bad_idx;
        name = test_name;
        d = exp_digit;
        m = exp_mode;
        seen = '0;
        bad_row = 0;
        bad_val = 0;
        bad_idx = 0;
        bad_row_val = '0;
        while (seen != 8'hff && bad_row < 16)   // one full frame
        begin
            @(posedge clk);
            r = lit_row(row);
            if (r < 0)
            begin
                if (bad_row == 0)
                    bad_row_val = row;
                bad_row++;
            end
            else
            begin
                seen[r] = 1'b1;
                pat = expected_cols(d, r);
                exp_r = (m == dz_pkg::MODE_SELECT) ? pat : '0;
                exp_g = (m == dz_pkg::MODE_LOCKED) ? pat : '0;
                if (colr !== exp_r || colg !== exp_g)
                begin
                    if (bad_val == 0)
                    begin
                        bad_idx = r;
                        want_r = exp_r;
                        want_g = exp_g;
                        got_r = colr;
                        got_g = colg;
                    end
                    bad_val++;
                end
            end
        end
        if (bad_row != 0)
        begin
            $display("ERROR %0s: row output %b does not light exactly one row", name, bad_row_val);
            fail_cnt++;
        end
        else if (bad_val != 0)
        begin
            $display("FAIL %0s: row %0d expected colr %b colg %b, actual colr %b colg %b",
                     name, bad_idx, want_r, want_g, got_r, got_g);
            fail_cnt++;
        end
        else
        begin
            $display("PASS %0s: digit %0d mode %0d", name, d, m);
            pass_cnt++;
        end
        chk_done = 1'b1;
    endtask

    initial
    begin
        chk_done = 1'b0;
        pass_cnt = 0;
        fail_cnt = 0;
        forever
        begin
            @(posedge clk);
            chk_done = 1'b0;
            if (chk_req)
                check_frame();
        end
    end

endmodule

/* bench/dz_tb.sv */
`timescale 1ns/10ps

module dz_tb;

    localparam int TICK_DIV        = 4;
    localparam int DEBOUNCE_CYCLES = 3;
    localparam int NAME_W          = 128;
    localparam int N_TESTS         = 12;

    localparam int FRAME_CYCLES  = 8 * TICK_DIV;
    localparam int BTN_CYCLES    = DEBOUNCE_CYCLES + 4;
    localparam int SETTLE_CYCLES = 2 * FRAME_CYCLES;
    // settle with its random part plus the checked frame
    localparam int SETTLE_BUDGET = SETTLE_CYCLES + 8 + FRAME_CYCLES + 2 * TICK_DIV;
    localparam int TIMEOUT_CYCLES = N_TESTS * (SETTLE_BUDGET + BTN_CYCLES) + 200;

    localparam int ACT_NONE   = 0;
    localparam int ACT_INC    = 1;
    localparam int ACT_DEC    = 2;
    localparam int ACT_CFM    = 3;
    localparam int ACT_GLITCH = 4;

    logic              clk = 1'b0;
    logic              rst;
    logic              btn_inc;
    logic              btn_dec;
    logic              btn_cfm;
    dz_pkg::line_t     row;
    dz_pkg::line_t     colr;
    dz_pkg::line_t     colg;

    logic              chk_req;
    dz_pkg::digit_t    exp_digit;
    dz_pkg::mode_t     exp_mode;
    logic [NAME_W-1:0] test_name;
    logic              chk_done;
    int                pass_cnt;
    int                fail_cnt;

    logic [NAME_W-1:0] name_tab [N_TESTS];
    int                act_tab  [N_TESTS];
    dz_pkg::digit_t    dig_tab  [N_TESTS];
    dz_pkg::mode_t     mode_tab [N_TESTS];

    integer            seed;
    int                cycles;
    int                extra;

    dz_top #(
        .TICK_DIV        (TICK_DIV),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) dut (
        .clk     (clk),
        .rst     (rst),
        .btn_inc (btn_inc),
        .btn_dec (btn_dec),
        .btn_cfm (btn_cfm),
        .row     (row),
        .colr    (colr),
        .colg    (colg)
    );

    dz_checker #(
        .NAME_W (NAME_W)
    ) chk (
        .clk       (clk),
        .row       (row),
        .colr      (colr),
        .colg      (colg),
        .chk_req   (chk_req),
        .exp_digit (exp_digit),
        .exp_mode  (exp_mode),
        .test_name (test_name),
        .chk_done  (chk_done),
        .pass_cnt  (pass_cnt),
        .fail_cnt  (fail_cnt)
    );

    task automatic add_entry(input int idx, input logic [NAME_W-1:0] name, input int act,
                             input dz_pkg::digit_t d, input dz_pkg::mode_t m);
        name_tab[idx] = name;
        act_tab[idx]  = act;
        dig_tab[idx]  = d;
        mode_tab[idx] = m;
    endtask

    task automatic load_table();
        add_entry(0,  "reset_blank", ACT_NONE,   3'd0, dz_pkg::MODE_SELECT);
        add_entry(1,  "inc_to_1",    ACT_INC,    3'd1, dz_pkg::MODE_SELECT);
        add_entry(2,  "inc_to_2",    ACT_INC,    3'd2, dz_pkg::MODE_SELECT);
        add_entry(3,  "inc_to_3",    ACT_INC,    3'd3, dz_pkg::MODE_SELECT);
        add_entry(4,  "inc_to_4",    ACT_INC,    3'd4, dz_pkg::MODE_SELECT);
        add_entry(5,  "inc_wrap_0",  ACT_INC,    3'd0, dz_pkg::MODE_SELECT);
        add_entry(6,  "dec_wrap_4",  ACT_DEC,    3'd4, dz_pkg::MODE_SELECT);
        add_entry(7,  "dec_to_3",    ACT_DEC,    3'd3, dz_pkg::MODE_SELECT);
        add_entry(8,  "cfm_lock",    ACT_CFM,    3'd3, dz_pkg::MODE_LOCKED);
        add_entry(9,  "inc_locked",  ACT_INC,    3'd3, dz_pkg::MODE_LOCKED);
        add_entry(10, "cfm_unlock",  ACT_CFM,    3'd3, dz_pkg::MODE_SELECT);
        add_entry(11, "glitch_inc",  ACT_GLITCH, 3'd3, dz_pkg::MODE_SELECT);
    endtask

    // hold one button over falling edges and a glitch for one cycle
    task automatic press_button(input int act);
        int hold;
        hold = (act == ACT_GLITCH) ? 1 : BTN_CYCLES;
        btn_inc = (act == ACT_INC) || (act == ACT_GLITCH);
        btn_dec = (act == ACT_DEC);
        btn_cfm = (act == ACT_CFM);
        repeat (hold) @(negedge clk);
        btn_inc = 1'b0;
        btn_dec = 1'b0;
        btn_cfm = 1'b0;
        if (act == ACT_GLITCH)
            repeat (BTN_CYCLES - 1) @(negedge clk);
    endtask

    initial
    begin
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("run timed out after %0d cycles without finishing the tests", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial
    begin
        rst = 1'b1;
        btn_inc = 1'b0;
        btn_dec = 1'b0;
        btn_cfm = 1'b0;
        chk_req = 1'b0;
        exp_digit = '0;
        exp_mode = dz_pkg::MODE_SELECT;
        test_name = '0;
        seed = 32'h97e22774;
        cycles = 0;
        load_table();
        repeat (3) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < N_TESTS; i++)
        begin
            press_button(act_tab[i]);
            extra = $unsigned($random(seed)) % 8;
            repeat (SETTLE_CYCLES + extra) @(negedge clk);
            exp_digit = dig_tab[i];
            exp_mode = mode_tab[i];
            test_name = name_tab[i];
            chk_req = 1'b1;
            @(negedge clk);
            chk_req = 1'b0;
            while (!chk_done)
                @(negedge clk);
        end
        $display("tests run %0d, passed %0d, failed %0d", N_TESTS, pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt == N_TESTS)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* filelist.f */
rtl/dz_pkg.sv
rtl/row_tick.sv
rtl/key_debounce.sv
rtl/dz_ctrl.sv
rtl/dz_scan.sv
rtl/dz_top.sv
bench/dz_checker.sv
bench/dz_tb.sv

/* Bender.yml */
package:
  name: dz_matrix

sources:
  - rtl/dz_pkg.sv
  - rtl/row_tick.sv
  - rtl/key_debounce.sv
  - rtl/dz_ctrl.sv
  - rtl/dz_scan.sv
  - rtl/dz_top.sv
  - target: simulation
    files:
      - bench/dz_checker.sv
      - bench/dz_tb.sv
